/* Makefile */
# Verilator build and run of the execute pipeline testbench
VERILATOR ?= verilator
TOP       ?= tb_exec_pipe
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* alu.sv */
`timescale 1ns/100ps

module alu (
    input  ex_pkg::xlen_t   a,
    input  ex_pkg::xlen_t   b,
    input  ex_pkg::alu_op_e op,
    output ex_pkg::xlen_t   res,
    output logic            eq,
    output logic            lt
);

    logic [4:0] shamt;
    logic       ltu;

    assign shamt = b[4:0];

    // Branch comparator, signed only in this subset
    assign eq  = a == b;
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;

    always_comb begin
        case (op)
            ex_pkg::ALU_ADD:  res = a + b;
            ex_pkg::ALU_SUB:  res = a - b;
            ex_pkg::ALU_AND:  res = a & b;
            ex_pkg::ALU_OR:   res = a | b;
            ex_pkg::ALU_XOR:  res = a ^ b;
            ex_pkg::ALU_SLT:  res = {31'b0, lt};
            ex_pkg::ALU_SLTU: res = {31'b0, ltu};
            ex_pkg::ALU_SLL:  res = a << shamt;
            ex_pkg::ALU_SRL:  res = a >> shamt;
            ex_pkg::ALU_SRA:  res = $signed(a) >>> shamt;
            // LUI immediate straight through
            ex_pkg::ALU_PASS: res = b;
            default:          res = a + b;
        endcase
    end

endmodule

/* ex_control.sv */
`timescale 1ns/100ps

module ex_control (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  ex_pkg::inst_t                          inst,
    input  logic                                   br_taken,
    input  logic                                   breq,
    input  logic                                   brlt,
    output ex_pkg::reg_idx_t [ex_pkg::NUM_SRC-1:0] src,
    output ex_pkg::alu_op_e                        alu_op,
    output logic                                   a_pc,
    output logic                                   b_imm,
    output logic                                   is_mul,
    output logic                                   br_suc,
    output logic                                   flush
);

    ex_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    logic            is_reg;
    logic            is_imm;
    logic            is_branch;
    logic            is_jal;
    logic            ctrl;
    logic            alt;
    logic            taken;
    logic            kill;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign is_reg    = opcode == ex_pkg::OP_REG;
    assign is_imm    = opcode == ex_pkg::OP_IMM;
    assign is_branch = opcode == ex_pkg::OP_BRANCH;
    assign is_jal    = opcode == ex_pkg::OP_JAL;
    assign ctrl      = ex_pkg::is_ctrl(inst);
    // SUB / SRA select bit
    assign alt       = inst[30];

    // Unused sources read as x0 so nothing gets forwarded
    assign src[0] = (is_reg || is_imm || is_branch) ? inst[19:15] : '0;
    assign src[1] = (is_reg || is_branch) ? inst[24:20] : '0;

    // AUIPC adds to pc
    assign a_pc  = opcode == ex_pkg::OP_AUIPC;
    assign b_imm = is_imm || (opcode == ex_pkg::OP_LUI) || (opcode == ex_pkg::OP_AUIPC);

    // Slot behind a mispredict never starts the multiplier
    assign is_mul = is_reg && (inst[31:25] == ex_pkg::F7_MUL) && !kill;

    always_comb begin
        alu_op = ex_pkg::ALU_ADD;
        if (opcode == ex_pkg::OP_LUI) begin
            alu_op = ex_pkg::ALU_PASS;
        end else if (is_reg || is_imm) begin
            case (funct3)
                // ADDI ignores bit 30, it belongs to the immediate
                3'b000:  alu_op = (is_reg && alt) ? ex_pkg::ALU_SUB : ex_pkg::ALU_ADD;
                3'b001:  alu_op = ex_pkg::ALU_SLL;
                3'b010:  alu_op = ex_pkg::ALU_SLT;
                3'b011:  alu_op = ex_pkg::ALU_SLTU;
                3'b100:  alu_op = ex_pkg::ALU_XOR;
                3'b101:  alu_op = alt ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
                3'b110:  alu_op = ex_pkg::ALU_OR;
                default: alu_op = ex_pkg::ALU_AND;
            endcase
        end
    end

    // Actual outcome
    always_comb begin
        case (funct3)
            3'b000:  taken = breq;
            3'b001:  taken = !breq;
            3'b100:  taken = brlt;
            3'b101:  taken = !brlt;
            default: taken = 1'b0;
        endcase
        if (is_jal) begin
            taken = 1'b1;
        end
    end

    // Anything but a branch or JAL counts as predicted right
    assign br_suc = ctrl ? (taken == br_taken) : 1'b1;
    assign flush  = ctrl && !br_suc && !kill;

    // Marks the wrong-path slot after a flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kill <= 1'b0;
        end else begin
            kill <= flush;
        end
    end

endmodule

/* ex_pkg.sv */
package ex_pkg;

    // Machine word, instruction word, register index
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [6:0]  funct7_t;

    // ADDI x0, x0, 0
    localparam inst_t NOP = 32'h0000_0013;

    // Integer source operands per instruction
    localparam int NUM_SRC = 2;

    // Shift-add iterations per product
    localparam int MUL_CYCLES = 32;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);
    typedef logic [MUL_CNT_W-1:0] mul_cnt_t;
    localparam mul_cnt_t MUL_LAST = mul_cnt_t'(MUL_CYCLES - 1);

    // RV32 major opcodes in use
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // M extension funct7
    localparam funct7_t F7_MUL = 7'b0000001;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS
    } alu_op_e;

    typedef enum logic [1:0] {
        NONE,
        MEM,
        WB
    } fwd_sel_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } mul_state_e;

    // Decoded instruction entering EX
    typedef struct packed {
        xlen_t pc;
        inst_t inst;
        xlen_t rd1;
        xlen_t rd2;
        xlen_t imm;
        logic  br_taken;
    } ex_in_t;

    // EX/MEM pipeline register
    typedef struct packed {
        xlen_t pc;
        xlen_t result;
        xlen_t rd2;
        inst_t inst;
        logic  br_suc;
        logic  flush;
    } ex_mem_t;

    // Writeback feedback toward EX
    typedef struct packed {
        xlen_t wdata;
        inst_t inst;
    } wb_fb_t;

    // Empty slot in EX/MEM
    localparam ex_mem_t MEM_BUBBLE = '{
        pc:     '0,
        result: '0,
        rd2:    '0,
        inst:   NOP,
        br_suc: 1'b0,
        flush:  1'b0
    };

    // Opcodes that write rd in this subset
    function automatic logic rd_we(inst_t inst);
        opcode_t op;
        op = inst[6:0];
        return (op == OP_REG) || (op == OP_IMM) || (op == OP_LUI) || (op == OP_AUIPC);
    endfunction

    // Conditional branch or JAL
    function automatic logic is_ctrl(inst_t inst);
        opcode_t op;
        op = inst[6:0];
        return (op == OP_BRANCH) || (op == OP_JAL);
    endfunction

endpackage

/* ex_stage.sv */
`timescale 1ns/100ps

module ex_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  ex_pkg::ex_in_t  ex_in,
    input  ex_pkg::wb_fb_t  wb,
    output ex_pkg::ex_mem_t mem,
    output logic            ex_stall
);

    ex_pkg::reg_idx_t [ex_pkg::NUM_SRC-1:0] src;
    ex_pkg::xlen_t [ex_pkg::NUM_SRC-1:0]    reg_val;
    ex_pkg::xlen_t [ex_pkg::NUM_SRC-1:0]    fwd;
    ex_pkg::alu_op_e                        alu_op;
    logic                                   a_pc;
    logic                                   b_imm;
    logic                                   is_mul;
    logic                                   br_suc;
    logic                                   flush;
    logic                                   breq;
    logic                                   brlt;
    ex_pkg::xlen_t                          alu_a;
    ex_pkg::xlen_t                          alu_b;
    ex_pkg::xlen_t                          alu_res;
    ex_pkg::xlen_t                          product;
    ex_pkg::xlen_t                          result;
    ex_pkg::ex_mem_t                        mem_next;

    // Register file values from decode
    assign reg_val[0] = ex_in.rd1;
    assign reg_val[1] = ex_in.rd2;

    // One forwarding unit per source
    for (genvar i = 0; i < ex_pkg::NUM_SRC; i++) begin : g_fwd
        operand_fwd operand_fwd_inst (
            .src     (src[i]),
            .reg_val (reg_val[i]),
            .mem     (mem),
            .wb      (wb),
            .operand (fwd[i])
        );
    end

    ex_control ex_control_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (ex_in.inst),
        .br_taken (ex_in.br_taken),
        .breq     (breq),
        .brlt     (brlt),
        .src      (src),
        .alu_op   (alu_op),
        .a_pc     (a_pc),
        .b_imm    (b_imm),
        .is_mul   (is_mul),
        .br_suc   (br_suc),
        .flush    (flush)
    );

    // Branches keep rs1/rs2 on the ALU for the compare
    assign alu_a = a_pc ? ex_in.pc : fwd[0];
    assign alu_b = b_imm ? ex_in.imm : fwd[1];

    alu alu_inst (
        .a   (alu_a),
        .b   (alu_b),
        .op  (alu_op),
        .res (alu_res),
        .eq  (breq),
        .lt  (brlt)
    );

    mul_unit mul_unit_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (is_mul),
        .a       (fwd[0]),
        .b       (fwd[1]),
        .busy    (ex_stall),
        .product (product)
    );

    // Control transfers carry their target
    always_comb begin
        if (is_mul) begin
            result = product;
        end else if (ex_pkg::is_ctrl(ex_in.inst)) begin
            result = ex_in.pc + ex_in.imm;
        end else begin
            result = alu_res;
        end
    end

    assign mem_next = '{
        pc:     ex_in.pc,
        result: result,
        rd2:    fwd[1],
        inst:   ex_in.inst,
        br_suc: br_suc,
        flush:  flush
    };

    // Bubble while the multiplier runs and in the slot behind a mispredict
    always_ff @(posedge clk) begin
        if (!rst_n || ex_stall || mem.flush) begin
            mem <= ex_pkg::MEM_BUBBLE;
        end else begin
            mem <= mem_next;
        end
    end

endmodule

/* exec_pipe.sv */
`timescale 1ns/100ps

module exec_pipe (
    input  logic            clk,
    input  logic            rst_n,
    input  ex_pkg::ex_in_t  ex_in,
    output ex_pkg::ex_mem_t mem,
    output ex_pkg::wb_fb_t  wb,
    output logic            ex_stall
);

    // EX stage with forwarding from mem and wb
    ex_stage ex_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_in    (ex_in),
        .wb       (wb),
        .mem      (mem),
        .ex_stall (ex_stall)
    );

    // MEM/WB register closing the forwarding loop
    wb_stage wb_stage_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem),
        .wb    (wb)
    );

endmodule

/* exec_pipe_properties.sv */
`timescale 1ns/100ps

module exec_pipe_properties (
    input logic            clk,
    input logic            rst_n,
    input ex_pkg::ex_in_t  ex_in,
    input ex_pkg::ex_mem_t mem,
    input ex_pkg::wb_fb_t  wb,
    input logic            ex_stall
);

    // Failed properties so far
    int unsigned fail_cnt = 0;

    // Reset empties both registers, multiplier idle while reset holds
    reset_state: assert property (@(posedge clk)
        !rst_n |=> mem.inst == ex_pkg::NOP && wb.inst == ex_pkg::NOP && !mem.flush
            && !mem.br_suc && (rst_n || !ex_stall))
        else begin
            fail_cnt++;
            $error("pipeline not empty after reset");
        end

    // Wrong-path slot behind a mispredict
    flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        mem.flush |=> mem.inst == ex_pkg::NOP && !mem.flush)
        else begin
            fail_cnt++;
            $error("entry after a flush is not a bubble");
        end

    flush_not_suc: assert property (@(posedge clk) disable iff (!rst_n)
        mem.flush |-> !mem.br_suc)
        else begin
            fail_cnt++;
            $error("flush raised on a correct prediction");
        end

    // Bubbles while the multiplier is busy
    stall_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        ex_stall |=> mem.inst == ex_pkg::NOP)
        else begin
            fail_cnt++;
            $error("instruction entered mem during a stall");
        end

    stall_only_mul: assert property (@(posedge clk) disable iff (!rst_n)
        ex_stall |-> ex_in.inst[6:0] == ex_pkg::OP_REG
            && ex_in.inst[31:25] == ex_pkg::F7_MUL)
        else begin
            fail_cnt++;
            $error("stall without a MUL in EX");
        end

endmodule

bind exec_pipe exec_pipe_properties exec_pipe_props_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_in    (ex_in),
    .mem      (mem),
    .wb       (wb),
    .ex_stall (ex_stall)
);

/* mul_unit.sv */
`timescale 1ns/100ps

module mul_unit (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          start,
    input  ex_pkg::xlen_t a,
    input  ex_pkg::xlen_t b,
    output logic          busy,
    output ex_pkg::xlen_t product
);

    ex_pkg::mul_state_e state;
    ex_pkg::mul_cnt_t   cnt;
    ex_pkg::xlen_t      mcand;
    ex_pkg::xlen_t      mplier;
    ex_pkg::xlen_t      acc;

    // Stall from the first EX cycle until the product is ready
    assign busy    = (state == ex_pkg::RUN) || ((state == ex_pkg::IDLE) && start);
    assign product = acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ex_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ex_pkg::IDLE: begin
                    if (start) begin
                        state <= ex_pkg::RUN;
                        cnt   <= '0;
                    end
                end
                ex_pkg::RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == ex_pkg::MUL_LAST) begin
                        state <= ex_pkg::DONE;
                    end
                end
                // Stage takes the product this cycle
                default: state <= ex_pkg::IDLE;
            endcase
        end
    end

    // One multiplier bit per cycle, low word only
    always_ff @(posedge clk) begin
        if ((state == ex_pkg::IDLE) && start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (state == ex_pkg::RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

/* operand_fwd.sv */
`timescale 1ns/100ps

module operand_fwd (
    input  ex_pkg::reg_idx_t src,
    input  ex_pkg::xlen_t    reg_val,
    input  ex_pkg::ex_mem_t  mem,
    input  ex_pkg::wb_fb_t   wb,
    output ex_pkg::xlen_t    operand
);

    ex_pkg::reg_idx_t mem_rd;
    ex_pkg::reg_idx_t wb_rd;
    logic             mem_hit;
    logic             wb_hit;
    ex_pkg::fwd_sel_e sel;

    // Destination fields of the two producers
    assign mem_rd = mem.inst[11:7];
    assign wb_rd  = wb.inst[11:7];

    // x0 never forwarded
    assign mem_hit = (src != '0) && ex_pkg::rd_we(mem.inst) && (mem_rd == src);
    assign wb_hit  = (src != '0) && ex_pkg::rd_we(wb.inst) && (wb_rd == src);

    // Youngest producer wins
    always_comb begin
        if (mem_hit) begin
            sel = ex_pkg::MEM;
        end else if (wb_hit) begin
            sel = ex_pkg::WB;
        end else begin
            sel = ex_pkg::NONE;
        end
    end

    always_comb begin
        case (sel)
            ex_pkg::MEM: operand = mem.result;
            ex_pkg::WB:  operand = wb.wdata;
            default:     operand = reg_val;
        endcase
    end

endmodule

/* tb_exec_pipe.sv */
`timescale 1ns/100ps

module tb_exec_pipe;

    logic            clk;
    logic            rst_n;
    ex_pkg::ex_in_t  ex_in;
    ex_pkg::ex_mem_t mem;
    ex_pkg::wb_fb_t  wb;
    logic            ex_stall;

    // Instructions in one run
    int unsigned      num_inst = 120;
    integer           seed;
    int unsigned      issued;
    int unsigned      drain;
    // Reference copies of the EX/MEM and MEM/WB registers
    ex_pkg::ex_mem_t  exp_mem;
    ex_pkg::wb_fb_t   exp_wb;
    // Multiplier operands as seen in the first stalled cycle
    ex_pkg::xlen_t    mul_a;
    ex_pkg::xlen_t    mul_b;
    logic             mul_seen;
    logic             prev_mul;
    ex_pkg::reg_idx_t prev_rd;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    exec_pipe exec_pipe_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_in    (ex_in),
        .mem      (mem),
        .wb       (wb),
        .ex_stall (ex_stall)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("ERR %0t %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    function automatic ex_pkg::ex_mem_t bubble();
        ex_pkg::ex_mem_t e;
        e = '0;
        e.inst = ex_pkg::NOP;
        return e;
    endfunction

    // Register writers of the subset
    function automatic logic writes_rd(ex_pkg::inst_t inst);
        logic [6:0] op;
        op = inst[6:0];
        return op == ex_pkg::OP_REG || op == ex_pkg::OP_IMM || op == ex_pkg::OP_LUI
            || op == ex_pkg::OP_AUIPC;
    endfunction

    // Youngest writer first, x0 reads the driven value
    function automatic ex_pkg::xlen_t source_value(ex_pkg::reg_idx_t idx, ex_pkg::xlen_t rv);
        if (idx == 5'd0) begin
            return rv;
        end else if (writes_rd(exp_mem.inst) && exp_mem.inst[11:7] == idx) begin
            return exp_mem.result;
        end else if (writes_rd(exp_wb.inst) && exp_wb.inst[11:7] == idx) begin
            return exp_wb.wdata;
        end
        return rv;
    endfunction

    function automatic ex_pkg::xlen_t alu_expect(ex_pkg::ex_in_t x, ex_pkg::xlen_t a,
                                                 ex_pkg::xlen_t b);
        ex_pkg::xlen_t r;
        case (x.inst[6:0])
            ex_pkg::OP_IMM:   r = a + x.imm;
            ex_pkg::OP_LUI:   r = x.imm;
            ex_pkg::OP_AUIPC: r = x.pc + x.imm;
            default: begin
                case (x.inst[14:12])
                    3'b000:  r = x.inst[30] ? a - b : a + b;
                    3'b001:  r = a << b[4:0];
                    3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011:  r = (a < b) ? 32'd1 : 32'd0;
                    3'b100:  r = a ^ b;
                    3'b101: begin
                        // SRA copies the sign bit in from the left
                        if (x.inst[30]) begin
                            r = $signed(a) >>> b[4:0];
                        end else begin
                            r = a >> b[4:0];
                        end
                    end
                    3'b110:  r = a | b;
                    default: r = a & b;
                endcase
            end
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(ex_pkg::inst_t inst, ex_pkg::xlen_t a, ex_pkg::xlen_t b);
        if (inst[6:0] == ex_pkg::OP_JAL) begin
            return 1'b1;
        end
        case (inst[14:12])
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    // Random instruction over x0..x7 so hazards come often
    task automatic gen_instruction(output ex_pkg::ex_in_t x);
        logic [3:0] kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [1:0] bsel;
        kind = 4'($unsigned($random(seed)) % 16);
        rd   = 5'($unsigned($random(seed)) % 8);
        rs1  = 5'($unsigned($random(seed)) % 8);
        rs2  = 5'($unsigned($random(seed)) % 8);
        bsel = 2'($random(seed));
        x.pc       = 32'h0000_1000 + 32'(issued * 4);
        x.rd1      = $random(seed);
        x.rd2      = $random(seed);
        x.imm      = $random(seed);
        x.br_taken = 1'($random(seed));
        // Consumer right behind a MUL reads its product
        if (prev_mul) begin
            kind = 4'd0;
            rs1  = prev_rd;
        end
        // Kinds 8 and 9 are SUB and SRA
        f3 = (kind == 4'd9) ? 3'b101 : kind[2:0];
        f7 = (kind == 4'd8 || kind == 4'd9) ? 7'h20 : 7'h00;
        if (kind < 4'd10) begin
            x.inst = {f7, rs2, rs1, f3, rd, ex_pkg::OP_REG};
        end else if (kind == 4'd10) begin
            x.inst = {12'h000, rs1, 3'b000, rd, ex_pkg::OP_IMM};
        end else if (kind == 4'd11) begin
            x.inst = {20'h00000, rd, ex_pkg::OP_LUI};
        end else if (kind == 4'd12) begin
            x.inst = {20'h00000, rd, ex_pkg::OP_AUIPC};
        end else if (kind == 4'd13) begin
            // BEQ, BNE, BLT, BGE
            x.inst = {7'h00, rs2, rs1, bsel[1], 1'b0, bsel[0], 5'd0, ex_pkg::OP_BRANCH};
        end else if (kind == 4'd14) begin
            x.inst = {25'h0, ex_pkg::OP_JAL};
        end else begin
            rd[0]  = 1'b1;
            x.inst = {ex_pkg::F7_MUL, rs2, rs1, 3'b000, rd, ex_pkg::OP_REG};
        end
        prev_mul = (kind == 4'd15);
        prev_rd  = rd;
    endtask

    task automatic compare_outputs;
        check_word("mem.inst", mem.inst, exp_mem.inst);
        check_word("mem.br_suc", mem.br_suc, exp_mem.br_suc);
        check_word("mem.flush", mem.flush, exp_mem.flush);
        check_word("wb.inst", wb.inst, exp_wb.inst);
        if (exp_mem.inst != ex_pkg::NOP) begin
            check_word("mem.pc", mem.pc, exp_mem.pc);
            check_word("mem.result", mem.result, exp_mem.result);
            check_word("mem.rd2", mem.rd2, exp_mem.rd2);
        end
        if (exp_wb.inst != ex_pkg::NOP) begin
            check_word("wb.wdata", wb.wdata, exp_wb.wdata);
        end
    endtask

    // One clock of the reference pipeline, evaluated while inputs are stable
    task automatic step_model(output logic accept);
        ex_pkg::ex_mem_t nxt;
        ex_pkg::inst_t   inst;
        ex_pkg::xlen_t   a;
        ex_pkg::xlen_t   b;
        logic [6:0]      op;
        logic            is_mul;
        inst   = ex_in.inst;
        op     = inst[6:0];
        is_mul = (op == ex_pkg::OP_REG) && (inst[31:25] == ex_pkg::F7_MUL);
        // rs1 used by R, I and branch forms, rs2 by R and branch
        a = source_value((op == ex_pkg::OP_REG || op == ex_pkg::OP_IMM
            || op == ex_pkg::OP_BRANCH) ? inst[19:15] : 5'd0, ex_in.rd1);
        b = source_value((op == ex_pkg::OP_REG || op == ex_pkg::OP_BRANCH)
            ? inst[24:20] : 5'd0, ex_in.rd2);
        // Live MUL stalls in its first cycle, nothing else ever does
        if (is_mul && !exp_mem.flush && !mul_seen) begin
            check_word("ex_stall", ex_stall, 32'd1);
        end else if (!is_mul || exp_mem.flush) begin
            check_word("ex_stall", ex_stall, 32'd0);
        end
        nxt    = bubble();
        accept = !ex_stall;
        if (ex_stall) begin
            if (!mul_seen) begin
                mul_a = a;
                mul_b = b;
            end
            mul_seen = 1'b1;
        end else if (!exp_mem.flush) begin
            nxt.pc     = ex_in.pc;
            nxt.inst   = inst;
            nxt.rd2    = b;
            nxt.br_suc = 1'b1;
            if (is_mul) begin
                nxt.result = mul_a * mul_b;
            end else if (op == ex_pkg::OP_BRANCH || op == ex_pkg::OP_JAL) begin
                nxt.result = ex_in.pc + ex_in.imm;
                nxt.br_suc = branch_taken(inst, a, b) == ex_in.br_taken;
                nxt.flush  = !nxt.br_suc;
            end else begin
                nxt.result = alu_expect(ex_in, a, b);
            end
        end
        if (!ex_stall) begin
            mul_seen = 1'b0;
        end
        // Flushed slot leaves WB without a write
        exp_wb.wdata = exp_mem.result;
        exp_wb.inst  = exp_mem.flush ? ex_pkg::NOP : exp_mem.inst;
        exp_mem      = nxt;
    endtask

    initial begin
        ex_pkg::ex_in_t nxt_in;
        logic           accept;
        seed     = 32'h9e8affea;
        rst_n    = 1'b0;
        ex_in    = '0;
        ex_in.inst = ex_pkg::NOP;
        issued   = 0;
        drain    = 0;
        mul_seen = 1'b0;
        prev_mul = 1'b0;
        prev_rd  = '0;
        exp_mem  = bubble();
        exp_wb   = '{wdata: '0, inst: ex_pkg::NOP};
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        gen_instruction(nxt_in);
        ex_in <= nxt_in;
        issued = 1;
        // Keep going until every instruction drained through WB
        while (issued < num_inst || drain < 4) begin
            @(negedge clk);
            compare_outputs();
            step_model(accept);
            @(posedge clk);
            if (accept) begin
                if (issued < num_inst) begin
                    gen_instruction(nxt_in);
                    ex_in <= nxt_in;
                    issued++;
                end else begin
                    nxt_in      = '0;
                    nxt_in.inst = ex_pkg::NOP;
                    ex_in <= nxt_in;
                    drain++;
                end
            end
        end
        @(negedge clk);
        if (exec_pipe_inst.exec_pipe_props_inst.fail_cnt != 0) begin
            fail_run("a protocol property of exec_pipe failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    // Every instruction could be a full multiply plus pipeline slack
    initial begin
        #(num_inst * (ex_pkg::MUL_CYCLES + 4) * 4);
        fail_run("watchdog expired before all instructions left the pipeline");
    end

endmodule

/* vlog.f */
ex_pkg.sv
operand_fwd.sv
ex_control.sv
alu.sv
mul_unit.sv
ex_stage.sv
wb_stage.sv
exec_pipe.sv
exec_pipe_properties.sv
tb_exec_pipe.sv

/* wb_stage.sv */
`timescale 1ns/100ps

module wb_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  ex_pkg::ex_mem_t mem,
    output ex_pkg::wb_fb_t  wb
);

    always_ff @(posedge clk) begin
        wb.wdata <= mem.result;
        // Flushed slot writes nothing
        if (!rst_n || mem.flush) begin
            wb.inst <= ex_pkg::NOP;
        end else begin
            wb.inst <= mem.inst;
        end
    end

endmodule
